/* id_pkg.sv */
package id_pkg;

    // ------------------------------------------------------------------------
    // Datapath types
    // ------------------------------------------------------------------------

    // One machine word for register values, operands, immediate and PC
    typedef logic [31:0] data_t;

    // Register file index
    typedef logic [4:0]  reg_addr_t;

    // Instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [25:0] jump_addr_t;

    // ------------------------------------------------------------------------
    // Operand forwarding
    // ------------------------------------------------------------------------

    // Source select for the A and B operands
    typedef logic [1:0]  fwd_sel_t;

    // Register file value without forwarding
    localparam fwd_sel_t FWD_REG    = 2'b00;
    localparam fwd_sel_t FWD_EX_MEM = 2'b01;
    localparam fwd_sel_t FWD_MEM_WB = 2'b10;
    // Youngest producer has the highest priority
    localparam fwd_sel_t FWD_ID_EX  = 2'b11;

    // Hardwired zero register
    localparam reg_addr_t REG_ZERO  = 5'd0;

endpackage

/* register_file.sv */
module register_file
    import id_pkg::*;
#(
    parameter int NB_DATA        = 32,
    parameter int NB_REG_ADDRESS = 5
)
(
    input  logic      i_clock,
    input  logic      i_rst_n,

    // Operand read ports
    input  reg_addr_t i_rs_addr,
    input  reg_addr_t i_rt_addr,
    output data_t     o_rs_data,
    output data_t     o_rt_data,

    // Debug read port
    input  reg_addr_t i_dbg_addr,
    output data_t     o_dbg_data,

    // Write-back port
    input  logic      i_wr_en,
    input  reg_addr_t i_wr_addr,
    input  data_t     i_wr_data
);

    localparam int N_REGS = 1 << NB_REG_ADDRESS;

    logic [NB_DATA-1:0] regs [N_REGS];

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != REG_ZERO)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // Read ports
    // ------------------------------------------------------------------------

    // A same-cycle write to the read address wins
    function automatic data_t read_port(input reg_addr_t addr);
        data_t value;
        if (addr == REG_ZERO) begin
            value = '0;
        end else if (i_wr_en && (i_wr_addr == addr)) begin
            value = i_wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign o_rs_data  = read_port(i_rs_addr);
    assign o_rt_data  = read_port(i_rt_addr);
    assign o_dbg_data = read_port(i_dbg_addr);

endmodule

/* forwarding_unit.sv */
module forwarding_unit
    import id_pkg::*;
#(
    parameter int NB_REG_ADDRESS = 5
)
(
    // Source registers of the instruction in decode
    input  reg_addr_t i_rs_addr,
    input  reg_addr_t i_rt_addr,

    // Destination registers of the later stages
    input  reg_addr_t i_rd_id_ex,
    input  reg_addr_t i_rd_ex_mem,
    input  reg_addr_t i_rd_mem_wb,
    input  logic      i_reg_write_id_ex,
    input  logic      i_reg_write_ex_mem,
    input  logic      i_reg_write_mem_wb,

    // Operand source selects
    output fwd_sel_t  o_fwd_a,
    output fwd_sel_t  o_fwd_b
);

    // Stage writes a nonzero register that matches the source
    function automatic logic qualifies(
        input logic                      wr,
        input logic [NB_REG_ADDRESS-1:0] rd,
        input logic [NB_REG_ADDRESS-1:0] src
    );
        return wr && (rd != '0) && (rd == src);
    endfunction

    // ------------------------------------------------------------------------
    // Fixed priority with the youngest stage first
    // ------------------------------------------------------------------------
    function automatic fwd_sel_t pick(input reg_addr_t src);
        fwd_sel_t sel;
        if (qualifies(i_reg_write_id_ex, i_rd_id_ex, src)) begin
            sel = FWD_ID_EX;
        end else if (qualifies(i_reg_write_ex_mem, i_rd_ex_mem, src)) begin
            sel = FWD_EX_MEM;
        end else if (qualifies(i_reg_write_mem_wb, i_rd_mem_wb, src)) begin
            sel = FWD_MEM_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    assign o_fwd_a = pick(i_rs_addr);
    assign o_fwd_b = pick(i_rt_addr);

endmodule

/* instruction_decode.sv */
module instruction_decode
    import id_pkg::*;
#(
    parameter int NB_DATA        = 32,
    parameter int NB_REG_ADDRESS = 5
)
(
    input  logic       i_clock,
    input  logic       i_rst_n,

    // Instruction from IF/ID
    input  data_t      i_instruction,

    // Return address for jump-and-link
    input  data_t      i_return_pc,
    input  logic       i_jump_link,

    // Forwarding sources
    input  logic       i_reg_write_id_ex,
    input  logic       i_reg_write_ex_mem,
    input  logic       i_reg_write_mem_wb,
    input  reg_addr_t  i_rd_id_ex,
    input  reg_addr_t  i_rd_ex_mem,
    input  reg_addr_t  i_rd_mem_wb,
    input  data_t      i_data_id_ex,
    input  data_t      i_data_ex_mem,
    input  data_t      i_data_mem_wb,

    // Write-back enabled by i_reg_write_mem_wb
    input  data_t      i_wb_data,
    input  reg_addr_t  i_wb_addr,

    // Debug read
    input  reg_addr_t  i_dbg_addr,
    output data_t      o_dbg_rdata,

    // Decoded operands and fields
    output data_t      o_rs_data,
    output data_t      o_rt_data,
    output data_t      o_cmp_a,
    output data_t      o_cmp_b,
    output data_t      o_immediate,
    output jump_addr_t o_jump_addr,
    output opcode_t    o_opcode,
    output reg_addr_t  o_rs,
    output reg_addr_t  o_rt,
    output reg_addr_t  o_rd
);

    data_t    reg_a;
    data_t    reg_b;
    data_t    opnd_a;
    data_t    opnd_b;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;

    // ------------------------------------------------------------------------
    // Field split
    // ------------------------------------------------------------------------
    assign o_opcode    = i_instruction[31:26];
    assign o_rs        = i_instruction[25:21];
    assign o_rt        = i_instruction[20:16];
    assign o_rd        = i_instruction[15:11];
    assign o_jump_addr = i_instruction[25:0];
    assign o_immediate = {{(NB_DATA - 16){i_instruction[15]}}, i_instruction[15:0]};

    register_file #(
        .NB_DATA        (NB_DATA),
        .NB_REG_ADDRESS (NB_REG_ADDRESS)
    ) u_register_file (
        .i_clock    (i_clock),
        .i_rst_n    (i_rst_n),
        .i_rs_addr  (o_rs),
        .i_rt_addr  (o_rt),
        .o_rs_data  (reg_a),
        .o_rt_data  (reg_b),
        .i_dbg_addr (i_dbg_addr),
        .o_dbg_data (o_dbg_rdata),
        .i_wr_en    (i_reg_write_mem_wb),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data)
    );

    forwarding_unit #(
        .NB_REG_ADDRESS (NB_REG_ADDRESS)
    ) u_forwarding_unit (
        .i_rs_addr          (o_rs),
        .i_rt_addr          (o_rt),
        .i_rd_id_ex         (i_rd_id_ex),
        .i_rd_ex_mem        (i_rd_ex_mem),
        .i_rd_mem_wb        (i_rd_mem_wb),
        .i_reg_write_id_ex  (i_reg_write_id_ex),
        .i_reg_write_ex_mem (i_reg_write_ex_mem),
        .i_reg_write_mem_wb (i_reg_write_mem_wb),
        .o_fwd_a            (fwd_a),
        .o_fwd_b            (fwd_b)
    );

    // ------------------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------------------
    function automatic data_t operand_mux(input fwd_sel_t sel, input data_t reg_val);
        data_t value;
        case (sel)
            FWD_ID_EX:  value = i_data_id_ex;
            FWD_EX_MEM: value = i_data_ex_mem;
            FWD_MEM_WB: value = i_data_mem_wb;
            default:    value = reg_val;
        endcase
        return value;
    endfunction

    assign opnd_a = operand_mux(fwd_a, reg_a);
    assign opnd_b = operand_mux(fwd_b, reg_b);

    // Branch compare sees the forwarded values and never the return PC
    assign o_cmp_a   = opnd_a;
    assign o_cmp_b   = opnd_b;

    assign o_rs_data = i_jump_link ? i_return_pc : opnd_a;
    assign o_rt_data = opnd_b;

endmodule

/* id_ex_register.sv */
module id_ex_register
    import id_pkg::*;
#(
    parameter int NB_DATA = 32
)
(
    input  logic               i_clock,
    input  logic               i_rst_n,

    // Pipeline control where flush wins
    input  logic               i_stall,
    input  logic               i_flush,

    // From decode
    input  logic [NB_DATA-1:0] i_rs_data,
    input  logic [NB_DATA-1:0] i_rt_data,
    input  logic [NB_DATA-1:0] i_cmp_a,
    input  logic [NB_DATA-1:0] i_cmp_b,
    input  logic [NB_DATA-1:0] i_immediate,
    input  jump_addr_t         i_jump_addr,
    input  opcode_t            i_opcode,
    input  reg_addr_t          i_rs,
    input  reg_addr_t          i_rt,
    input  reg_addr_t          i_rd,

    // To execute
    output logic               o_valid,
    output logic [NB_DATA-1:0] o_rs_data,
    output logic [NB_DATA-1:0] o_rt_data,
    output logic [NB_DATA-1:0] o_cmp_a,
    output logic [NB_DATA-1:0] o_cmp_b,
    output logic [NB_DATA-1:0] o_immediate,
    output jump_addr_t         o_jump_addr,
    output opcode_t            o_opcode,
    output reg_addr_t          o_rs,
    output reg_addr_t          o_rt,
    output reg_addr_t          o_rd
);

    logic clear;
    logic load;

    // Bubble on flush, hold on stall
    assign clear = i_flush;
    assign load  = !i_flush && !i_stall;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_rs_data   <= '0;
            o_rt_data   <= '0;
            o_cmp_a     <= '0;
            o_cmp_b     <= '0;
            o_immediate <= '0;
            o_jump_addr <= '0;
            o_opcode    <= '0;
            o_rs        <= '0;
            o_rt        <= '0;
            o_rd        <= '0;
        end else if (clear) begin
            o_valid     <= 1'b0;
            o_rs_data   <= '0;
            o_rt_data   <= '0;
            o_cmp_a     <= '0;
            o_cmp_b     <= '0;
            o_immediate <= '0;
            o_jump_addr <= '0;
            o_opcode    <= '0;
            o_rs        <= '0;
            o_rt        <= '0;
            o_rd        <= '0;
        end else if (load) begin
            o_valid     <= 1'b1;
            o_rs_data   <= i_rs_data;
            o_rt_data   <= i_rt_data;
            o_cmp_a     <= i_cmp_a;
            o_cmp_b     <= i_cmp_b;
            o_immediate <= i_immediate;
            o_jump_addr <= i_jump_addr;
            o_opcode    <= i_opcode;
            o_rs        <= i_rs;
            o_rt        <= i_rt;
            o_rd        <= i_rd;
        end
    end

endmodule

/* debug_apb_slave.sv */
module debug_apb_slave
    import id_pkg::*;
#(
    parameter int NB_DATA = 32
)
(
    input  logic               i_clock,
    input  logic               i_rst_n,

    // APB slave
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [7:0]         i_paddr,
    output logic [NB_DATA-1:0] o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,

    // Register file debug port
    output reg_addr_t          o_dbg_addr,
    input  data_t              i_dbg_rdata
);

    logic wait_done;
    logic access_first;

    // Word index into the register file
    assign o_dbg_addr = i_paddr[6:2];

    // First access cycle with ready still low
    assign access_first = i_psel && i_penable && !wait_done;

    // ------------------------------------------------------------------------
    // Wait-state flag and response
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wait_done <= 1'b0;
            o_pslverr <= 1'b0;
        end else begin
            // High for exactly the second access cycle
            wait_done <= access_first;
            o_pslverr <= access_first && i_pwrite;
        end
    end

    assign o_pready = wait_done;

    // Read data captured at the end of the wait state
    always_ff @(posedge i_clock) begin
        if (access_first && !i_pwrite) begin
            o_prdata <= i_dbg_rdata;
        end
    end

endmodule

/* id_stage_top.sv */
module id_stage_top
    import id_pkg::*;
#(
    parameter int NB_DATA        = 32,
    parameter int NB_REG_ADDRESS = 5
)
(
    input  logic               i_clock,
    input  logic               i_rst_n,

    // Instruction and jump-and-link
    input  data_t              i_instruction,
    input  logic               i_jump_link,
    input  data_t              i_return_pc,

    // Forwarding sources
    input  logic               i_reg_write_id_ex,
    input  logic               i_reg_write_ex_mem,
    input  logic               i_reg_write_mem_wb,
    input  reg_addr_t          i_rd_id_ex,
    input  reg_addr_t          i_rd_ex_mem,
    input  reg_addr_t          i_rd_mem_wb,
    input  data_t              i_data_id_ex,
    input  data_t              i_data_ex_mem,
    input  data_t              i_data_mem_wb,

    // Write-back
    input  data_t              i_wb_data,
    input  reg_addr_t          i_wb_addr,

    // Pipeline control
    input  logic               i_stall,
    input  logic               i_flush,

    // Debug APB
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [7:0]         i_paddr,
    output logic [NB_DATA-1:0] o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,

    // ID/EX outputs
    output logic               o_valid,
    output logic [NB_DATA-1:0] o_rs_data,
    output logic [NB_DATA-1:0] o_rt_data,
    output logic [NB_DATA-1:0] o_cmp_a,
    output logic [NB_DATA-1:0] o_cmp_b,
    output logic [NB_DATA-1:0] o_immediate,
    output jump_addr_t         o_jump_addr,
    output opcode_t            o_opcode,
    output reg_addr_t          o_rs,
    output reg_addr_t          o_rt,
    output reg_addr_t          o_rd
);

    reg_addr_t  dbg_addr;
    data_t      dbg_rdata;
    data_t      dec_rs_data;
    data_t      dec_rt_data;
    data_t      dec_cmp_a;
    data_t      dec_cmp_b;
    data_t      dec_immediate;
    jump_addr_t dec_jump_addr;
    opcode_t    dec_opcode;
    reg_addr_t  dec_rs;
    reg_addr_t  dec_rt;
    reg_addr_t  dec_rd;

    // ------------------------------------------------------------------------
    // Debug access
    // ------------------------------------------------------------------------
    debug_apb_slave #(
        .NB_DATA (NB_DATA)
    ) u_debug_apb_slave (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel),
        .i_penable   (i_penable),
        .i_pwrite    (i_pwrite),
        .i_paddr     (i_paddr),
        .o_prdata    (o_prdata),
        .o_pready    (o_pready),
        .o_pslverr   (o_pslverr),
        .o_dbg_addr  (dbg_addr),
        .i_dbg_rdata (dbg_rdata)
    );

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    instruction_decode #(
        .NB_DATA        (NB_DATA),
        .NB_REG_ADDRESS (NB_REG_ADDRESS)
    ) u_instruction_decode (
        .i_clock            (i_clock),
        .i_rst_n            (i_rst_n),
        .i_instruction      (i_instruction),
        .i_return_pc        (i_return_pc),
        .i_jump_link        (i_jump_link),
        .i_reg_write_id_ex  (i_reg_write_id_ex),
        .i_reg_write_ex_mem (i_reg_write_ex_mem),
        .i_reg_write_mem_wb (i_reg_write_mem_wb),
        .i_rd_id_ex         (i_rd_id_ex),
        .i_rd_ex_mem        (i_rd_ex_mem),
        .i_rd_mem_wb        (i_rd_mem_wb),
        .i_data_id_ex       (i_data_id_ex),
        .i_data_ex_mem      (i_data_ex_mem),
        .i_data_mem_wb      (i_data_mem_wb),
        .i_wb_data          (i_wb_data),
        .i_wb_addr          (i_wb_addr),
        .i_dbg_addr         (dbg_addr),
        .o_dbg_rdata        (dbg_rdata),
        .o_rs_data          (dec_rs_data),
        .o_rt_data          (dec_rt_data),
        .o_cmp_a            (dec_cmp_a),
        .o_cmp_b            (dec_cmp_b),
        .o_immediate        (dec_immediate),
        .o_jump_addr        (dec_jump_addr),
        .o_opcode           (dec_opcode),
        .o_rs               (dec_rs),
        .o_rt               (dec_rt),
        .o_rd               (dec_rd)
    );

    // ------------------------------------------------------------------------
    // ID/EX pipeline register
    // ------------------------------------------------------------------------
    id_ex_register #(
        .NB_DATA (NB_DATA)
    ) u_id_ex_register (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_flush     (i_flush),
        .i_rs_data   (dec_rs_data),
        .i_rt_data   (dec_rt_data),
        .i_cmp_a     (dec_cmp_a),
        .i_cmp_b     (dec_cmp_b),
        .i_immediate (dec_immediate),
        .i_jump_addr (dec_jump_addr),
        .i_opcode    (dec_opcode),
        .i_rs        (dec_rs),
        .i_rt        (dec_rt),
        .i_rd        (dec_rd),
        .o_valid     (o_valid),
        .o_rs_data   (o_rs_data),
        .o_rt_data   (o_rt_data),
        .o_cmp_a     (o_cmp_a),
        .o_cmp_b     (o_cmp_b),
        .o_immediate (o_immediate),
        .o_jump_addr (o_jump_addr),
        .o_opcode    (o_opcode),
        .o_rs        (o_rs),
        .o_rt        (o_rt),
        .o_rd        (o_rd)
    );

endmodule

/* tb_id_stage_sva.sv */
module tb_id_stage_sva (
    input logic i_clock,
    input logic i_rst_n,
    input logic i_psel,
    input logic i_penable,
    input logic i_pwrite,
    input logic o_pready,
    input logic o_pslverr,
    input logic i_flush,
    input logic o_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // APB response
    // ------------------------------------------------------------------------
    ready_in_access: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_pready |-> (i_psel && i_penable)
    ) else $error("o_pready high outside an APB access phase");

    slverr_on_write: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        o_pslverr |-> i_pwrite
    ) else $error("o_pslverr high on a read");

    // Bubble follows a flush
    flush_clears_valid: assert property (
        @(posedge i_clock) disable iff (!i_rst_n)
        i_flush |=> !o_valid
    ) else $error("o_valid high in the cycle after i_flush");

endmodule

bind debug_apb_slave tb_id_stage_sva apb_checks (
    .i_clock, .i_rst_n, .i_psel, .i_penable, .i_pwrite, .o_pready, .o_pslverr,
    .i_flush (1'b0), .o_valid (1'b0)
);

bind id_ex_register tb_id_stage_sva pipe_checks (
    .i_clock, .i_rst_n, .i_flush, .o_valid,
    .i_psel (1'b0), .i_penable (1'b0), .i_pwrite (1'b0), .o_pready (1'b0), .o_pslverr (1'b0)
);

/* tb_id_stage.sv */
module tb_id_stage
    import id_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 5;
    localparam int N_VECTORS       = 14;
    localparam int N_COLS          = 17;
    localparam int WATCHDOG_CYCLES = N_VECTORS * 4 + 20;

    // Column layout of id_vectors.txt
    localparam int COL_KIND       = 0;
    localparam int COL_INSTR      = 1;
    localparam int COL_FLAGS      = 2;
    localparam int COL_ADDRS      = 3;
    localparam int COL_D_ID_EX    = 4;
    localparam int COL_D_EX_MEM   = 5;
    localparam int COL_D_MEM_WB   = 6;
    localparam int COL_WB_DATA    = 7;
    localparam int COL_RET_PC     = 8;
    localparam int COL_EXP_VALID  = 9;
    localparam int COL_EXP_RS     = 10;
    localparam int COL_EXP_RT     = 11;
    localparam int COL_EXP_CMP_A  = 12;
    localparam int COL_EXP_CMP_B  = 13;
    localparam int COL_EXP_IMM    = 14;
    localparam int COL_EXP_FIELDS = 15;
    localparam int COL_EXP_JUMP   = 16;

    logic        i_clock;
    logic        i_rst_n;
    data_t       i_instruction;
    logic        i_jump_link;
    data_t       i_return_pc;
    logic        i_reg_write_id_ex;
    logic        i_reg_write_ex_mem;
    logic        i_reg_write_mem_wb;
    reg_addr_t   i_rd_id_ex;
    reg_addr_t   i_rd_ex_mem;
    reg_addr_t   i_rd_mem_wb;
    data_t       i_data_id_ex;
    data_t       i_data_ex_mem;
    data_t       i_data_mem_wb;
    data_t       i_wb_data;
    reg_addr_t   i_wb_addr;
    logic        i_stall;
    logic        i_flush;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [7:0]  i_paddr;
    data_t       o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        o_valid;
    data_t       o_rs_data;
    data_t       o_rt_data;
    data_t       o_cmp_a;
    data_t       o_cmp_b;
    data_t       o_immediate;
    jump_addr_t  o_jump_addr;
    opcode_t     o_opcode;
    reg_addr_t   o_rs;
    reg_addr_t   o_rt;
    reg_addr_t   o_rd;

    logic [31:0] vectors [N_VECTORS * N_COLS];
    logic [31:0] row [N_COLS];

    id_stage_top id_stage_top_inst (.*);

    always #(CLK_PERIOD / 2) i_clock = ~i_clock;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Flags are one hex digit each, addresses one byte each
    task automatic apply_inputs();
        i_instruction      = row[COL_INSTR];
        i_jump_link        = row[COL_FLAGS][20];
        i_stall            = row[COL_FLAGS][16];
        i_flush            = row[COL_FLAGS][12];
        i_reg_write_id_ex  = row[COL_FLAGS][8];
        i_reg_write_ex_mem = row[COL_FLAGS][4];
        i_reg_write_mem_wb = row[COL_FLAGS][0];
        i_rd_id_ex         = row[COL_ADDRS][28:24];
        i_rd_ex_mem        = row[COL_ADDRS][20:16];
        i_rd_mem_wb        = row[COL_ADDRS][12:8];
        i_wb_addr          = row[COL_ADDRS][4:0];
        i_data_id_ex       = row[COL_D_ID_EX];
        i_data_ex_mem      = row[COL_D_EX_MEM];
        i_data_mem_wb      = row[COL_D_MEM_WB];
        i_wb_data          = row[COL_WB_DATA];
        i_return_pc        = row[COL_RET_PC];
    endtask

    // ID/EX shows the decoded instruction one edge later
    task automatic run_pipeline_step();
        @(posedge i_clock);
        #(DRIVE_DELAY);
        check_value("o_valid", 32'(o_valid), row[COL_EXP_VALID]);
        check_value("o_rs_data", o_rs_data, row[COL_EXP_RS]);
        check_value("o_rt_data", o_rt_data, row[COL_EXP_RT]);
        check_value("o_cmp_a", o_cmp_a, row[COL_EXP_CMP_A]);
        check_value("o_cmp_b", o_cmp_b, row[COL_EXP_CMP_B]);
        check_value("o_immediate", o_immediate, row[COL_EXP_IMM]);
        check_value("o_opcode", 32'(o_opcode), 32'(row[COL_EXP_FIELDS][29:24]));
        check_value("o_rs", 32'(o_rs), 32'(row[COL_EXP_FIELDS][20:16]));
        check_value("o_rt", 32'(o_rt), 32'(row[COL_EXP_FIELDS][12:8]));
        check_value("o_rd", 32'(o_rd), 32'(row[COL_EXP_FIELDS][4:0]));
        check_value("o_jump_addr", 32'(o_jump_addr), row[COL_EXP_JUMP]);
    endtask

    task automatic run_apb_access(input logic write);
        int cycles;
        i_paddr   = row[COL_INSTR][7:0];
        i_pwrite  = write;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        @(posedge i_clock);
        #(DRIVE_DELAY);
        i_penable = 1'b1;
        cycles    = 1;
        // Ready stays low through the first access cycle
        @(negedge i_clock);
        check_value("o_pready", 32'(o_pready), 32'd0);
        // Count access cycles until the slave is ready
        do begin
            @(posedge i_clock);
            #(DRIVE_DELAY);
            cycles++;
        end while (!o_pready);
        check_value("apb_latency", cycles, 32'd2);
        check_value("o_pslverr", 32'(o_pslverr), row[COL_EXP_VALID]);
        if (!write) begin
            check_value("o_prdata", o_prdata, row[COL_EXP_RS]);
        end
        // Transfer completes on the edge that samples ready
        @(posedge i_clock);
        #(DRIVE_DELAY);
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        i_clock   = 1'b0;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        row       = '{default: '0};
        apply_inputs();
        $readmemh("id_vectors.txt", vectors);

        repeat (RESET_CYCLES) @(posedge i_clock);
        #(DRIVE_DELAY);
        check_value("o_valid", 32'(o_valid), 32'd0);
        check_value("o_rs_data", o_rs_data, 32'd0);
        check_value("o_pready", 32'(o_pready), 32'd0);
        check_value("o_pslverr", 32'(o_pslverr), 32'd0);
        i_rst_n = 1'b1;

        for (int v = 0; v < N_VECTORS; v++) begin
            for (int c = 0; c < N_COLS; c++) begin
                row[c] = vectors[v * N_COLS + c];
            end
            apply_inputs();
            case (row[COL_KIND])
                32'd0:   run_pipeline_step();
                32'd1:   run_apb_access(1'b0);
                32'd2:   run_apb_access(1'b1);
                default: begin
                    $display("Vector %0d has an unknown kind %0h", v, row[COL_KIND]);
                    $display("TEST FAILED");
                    $fatal(1, "Bad vector file");
                end
            endcase
        end

        $display("TEST OK");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* id_vectors.txt */
// kind(0 step,1 apb rd,2 apb wr) instr/paddr flags(jl stall flush we_ie we_em we_mw) addrs(ie em mw wb)
// d_ie d_em d_mw wb_data ret_pc | valid/slverr rs/prdata rt cmp_a cmp_b imm fields(op rs rt rd) jump
0 00A51820 000001 00000005 0 0 0 1234 0 1 1234 1234 1234 1234 00001820 00050503 0A51820
0 20A0FFFF 000101 00000000 BAD0 0 0 DEAD 0 1 1234 0 1234 0 FFFFFFFF 0805001F 0A0FFFF
0 8C058004 000001 00000009 0 0 0 9999 0 1 0 1234 0 1234 FFFF8004 23000510 0058004
0 01251022 000111 09090900 AAAA BBBB CCCC 0 0 1 AAAA 1234 AAAA 1234 00001022 00090502 1251022
0 01243025 000111 04090900 AAAA BBBB CCCC 0 0 1 BBBB AAAA BBBB AAAA 00003025 00090406 1243025
0 01290820 000001 09090900 AAAA BBBB CCCC 0 0 1 CCCC CCCC CCCC CCCC 00000820 00090901 1290820
0 0C123456 100000 00000000 0 0 0 0 00400008 1 00400008 0 0 0 00003456 03001206 0123456
0 2129FFF0 010000 00000000 0 0 0 0 0 1 00400008 0 0 0 00003456 03001206 0123456
0 2129FFF0 011000 00000000 0 0 0 0 0 0 0 0 0 0 0 0 0
0 10A9FFFE 000000 00000000 0 0 0 0 0 1 1234 9999 1234 9999 FFFFFFFE 0405091F 0A9FFFE
1 24 0 0 0 0 0 0 0 0 9999 0 0 0 0 0 0
2 14 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0
1 14 0 0 0 0 0 0 0 0 1234 0 0 0 0 0 0
1 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* sim.f */
id_pkg.sv
register_file.sv
forwarding_unit.sv
instruction_decode.sv
id_ex_register.sv
debug_apb_slave.sv
id_stage_top.sv
tb_id_stage_sva.sv
tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ID stage testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_id_stage -f sim.f -o tb_id_stage

# The testbench stops with a nonzero status on failure, the log decides
./obj_dir/tb_id_stage > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
